//--- hw/inst_queue.sv
`timescale 1ns/1ns

module inst_queue import rv_fetch_pkg::*, iq_queue_pkg::*; #(
    parameter int DEPTH = IQ_DEPTH_DEF
) (
    input  logic              clk,
    input  logic              rst_n,
    // icache side
    input  logic              icache_valid_i,
    input  pc_t               icache_pc_i,
    input  logic [LINE_W-1:0] icache_data_i,
    output logic              instq_full_o,
    // decode side
    output logic              iq0_vld_o,
    output pc_t               iq0_pc_o,
    output inst_t             iq0_inst_o,
    output logic              iq1_vld_o,
    output pc_t               iq1_pc_o,
    output inst_t             iq1_inst_o,
    // backend
    input  logic              stall_iq_i,
    input  logic              flush_iq_i
);

    localparam int PTR_W = iq_ptr_w(DEPTH);

    fetch_pc_u                     fetch_pc;
    inst_t [LINE_INSTS-1:0]        al_inst;
    pc_t   [LINE_INSTS-1:0]        al_pc;
    logic  [SLOT_W:0]              al_cnt;
    logic                          push;
    logic  [PTR_W-1:0]             wptr;
    logic  [PTR_W-1:0]             rptr;
    logic  [IQ_READ_W-1:0]         rd_vld;
    inst_t [IQ_READ_W-1:0]         rd_inst;
    pc_t   [IQ_READ_W-1:0]         rd_pc;

    assign fetch_pc.flat = icache_pc_i;

    iq_line_align u_align (
        .line_i    (icache_data_i),
        .pc_i      (fetch_pc),
        .inst_o    (al_inst),
        .inst_pc_o (al_pc),
        .count_o   (al_cnt)
    );

    iq_ptr_ctrl #(.DEPTH(DEPTH), .PTR_W(PTR_W)) u_ptr (
        .clk          (clk),
        .rst_n        (rst_n),
        .line_valid_i (icache_valid_i),
        .count_i      (al_cnt),
        .stall_i      (stall_iq_i),
        .flush_i      (flush_iq_i),
        .push_o       (push),
        .wptr_o       (wptr),
        .rptr_o       (rptr),
        .rd_vld_o     (rd_vld),
        .full_o       (instq_full_o)
    );

    iq_store #(.DEPTH(DEPTH), .PTR_W(PTR_W)) u_store (
        .clk       (clk),
        .push_i    (push),
        .wptr_i    (wptr),
        .count_i   (al_cnt),
        .inst_i    (al_inst),
        .inst_pc_i (al_pc),
        .rptr_i    (rptr),
        .rd_inst_o (rd_inst),
        .rd_pc_o   (rd_pc)
    );

    // lane 1 is valid only behind lane 0
    assign iq0_vld_o  = rd_vld[0];
    assign iq0_pc_o   = rd_pc[0];
    assign iq0_inst_o = rd_inst[0];
    assign iq1_vld_o  = rd_vld[1];
    assign iq1_pc_o   = rd_pc[1];
    assign iq1_inst_o = rd_inst[1];

endmodule

//--- hw/iq_line_align.sv
`timescale 1ns/1ns

module iq_line_align import rv_fetch_pkg::*; (
    input  logic [LINE_W-1:0]      line_i,
    input  fetch_pc_u              pc_i,
    output inst_t [LINE_INSTS-1:0] inst_o,
    output pc_t   [LINE_INSTS-1:0] inst_pc_o,
    output logic  [SLOT_W:0]       count_o
);

    logic [SLOT_W-1:0] slot;

    assign slot = pc_i.fld.slot;

    // slots before the fetch pc are dropped
    assign count_o = (SLOT_W+1)'(LINE_INSTS) - (SLOT_W+1)'(slot);

    always_comb begin
        logic [SLOT_W:0] src;
        for (int k = 0; k < LINE_INSTS; k++) begin
            src = (SLOT_W+1)'(slot) + (SLOT_W+1)'(k);
            if ((SLOT_W+1)'(k) < count_o) begin
                inst_o[k]    = line_i[src*INST_W +: INST_W];
                // same line tag with the source slot
                inst_pc_o[k] = {pc_i.fld.tag, src[SLOT_W-1:0], OFF_W'(0)};
            end else begin
                inst_o[k]    = '0;
                inst_pc_o[k] = '0;
            end
        end
    end

endmodule

//--- hw/iq_ptr_ctrl.sv
`timescale 1ns/1ns

module iq_ptr_ctrl import rv_fetch_pkg::*, iq_queue_pkg::*; #(
    parameter int DEPTH = 32,
    parameter int PTR_W = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 line_valid_i,
    input  logic [SLOT_W:0]      count_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    output logic                 push_o,
    output logic [PTR_W-1:0]     wptr_o,
    output logic [PTR_W-1:0]     rptr_o,
    output logic [IQ_READ_W-1:0] rd_vld_o,
    output logic                 full_o
);

    // extra msb tells a full queue from an empty one
    logic [PTR_W:0] wptr;
    logic [PTR_W:0] rptr;
    logic [PTR_W:0] occ;
    logic [PTR_W:0] free_cnt;
    logic [PTR_W:0] pop_cnt;

    assign occ      = wptr - rptr;
    assign free_cnt = (PTR_W+1)'(DEPTH) - occ;

    // a whole line must fit, whatever its slot
    assign full_o = free_cnt < (PTR_W+1)'(LINE_INSTS);
    assign push_o = line_valid_i && !full_o;

    always_comb begin
        pop_cnt = '0;
        for (int r = 0; r < IQ_READ_W; r++) begin
            rd_vld_o[r] = occ > (PTR_W+1)'(r);
            if (!stall_i && rd_vld_o[r]) begin
                pop_cnt = pop_cnt + (PTR_W+1)'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr <= '0;
            rptr <= '0;
        end else if (flush_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push_o) begin
                wptr <= wptr + (PTR_W+1)'(count_i);
            end
            rptr <= rptr + pop_cnt;
        end
    end

    assign wptr_o = wptr[PTR_W-1:0];
    assign rptr_o = rptr[PTR_W-1:0];

    occ_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) occ <= (PTR_W+1)'(DEPTH)
    );

    // the aligned count of an accepted line never overruns the free entries
    push_fits: assert property (
        @(posedge clk) disable iff (!rst_n) push_o |-> free_cnt >= (PTR_W+1)'(count_i)
    );

endmodule

//--- hw/iq_queue_pkg.sv
package iq_queue_pkg;

    // default entry count, must be a power of two
    localparam int IQ_DEPTH_DEF = 32;

    // instructions handed to decode per cycle
    localparam int IQ_READ_W    = 2;

    // index width for a queue of the given depth
    function automatic int iq_ptr_w(input int depth);
        return $clog2(depth);
    endfunction

endpackage

//--- hw/iq_store.sv
`timescale 1ns/1ns

module iq_store import rv_fetch_pkg::*, iq_queue_pkg::*; #(
    parameter int DEPTH = 32,
    parameter int PTR_W = 5
) (
    input  logic                          clk,
    input  logic                          push_i,
    input  logic [PTR_W-1:0]              wptr_i,
    input  logic [SLOT_W:0]               count_i,
    input  inst_t [LINE_INSTS-1:0]        inst_i,
    input  pc_t   [LINE_INSTS-1:0]        inst_pc_i,
    input  logic [PTR_W-1:0]              rptr_i,
    output inst_t [IQ_READ_W-1:0]         rd_inst_o,
    output pc_t   [IQ_READ_W-1:0]         rd_pc_o
);

    inst_t mem_inst [DEPTH];
    pc_t   mem_pc   [DEPTH];

    // lanes 0..count-1 land in consecutive entries, wrapping at depth
    always_ff @(posedge clk) begin
        if (push_i) begin
            for (int k = 0; k < LINE_INSTS; k++) begin
                if ((SLOT_W+1)'(k) < count_i) begin
                    mem_inst[wptr_i + PTR_W'(k)] <= inst_i[k];
                    mem_pc[wptr_i + PTR_W'(k)]   <= inst_pc_i[k];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < IQ_READ_W; r++) begin
            rd_inst_o[r] = mem_inst[rptr_i + PTR_W'(r)];
            rd_pc_o[r]   = mem_pc[rptr_i + PTR_W'(r)];
        end
    end

endmodule

//--- hw/rv_fetch_pkg.sv
package rv_fetch_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int INST_BYTES = 4;
    localparam int LINE_INSTS = 16;
    localparam int LINE_W     = LINE_INSTS * INST_W;
    localparam int SLOT_W     = $clog2(LINE_INSTS);

    // byte offset within one instruction, tag above the line
    localparam int OFF_W      = $clog2(INST_BYTES);
    localparam int TAG_W      = XLEN - SLOT_W - OFF_W;

    typedef logic [XLEN-1:0]   pc_t;
    typedef logic [INST_W-1:0] inst_t;

    // fetch pc, seen as a flat address or split into line fields
    typedef union packed {
        pc_t flat;
        struct packed {
            logic [TAG_W-1:0]  tag;
            logic [SLOT_W-1:0] slot;
            logic [OFF_W-1:0]  byte_off;
        } fld;
    } fetch_pc_u;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_inst_queue -f sources.f -o sim_inst_queue

./obj_dir/sim_inst_queue | tee sim.log

grep -q "TESTBENCH PASSED" sim.log || { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"

//--- sources.f
hw/rv_fetch_pkg.sv
hw/iq_queue_pkg.sv
hw/iq_line_align.sv
hw/iq_ptr_ctrl.sv
hw/iq_store.sv
hw/inst_queue.sv
tests/tb_inst_queue.sv

//--- tests/tb_inst_queue.sv
`timescale 1ns/1ns

module tb_inst_queue import rv_fetch_pkg::*; ();

    localparam int DEPTH         = 32;
    localparam int RESET_CYCLES  = 3;
    localparam int MARGIN_CYCLES = 50;

    localparam int OP_PUSH       = 0;
    localparam int OP_RUN        = 1;
    localparam int OP_FLUSH      = 2;
    localparam int OP_PUSH_FLUSH = 3;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              icache_valid_i;
    pc_t               icache_pc_i;
    logic [LINE_W-1:0] icache_data_i;
    logic              instq_full_o;
    logic              iq0_vld_o;
    pc_t               iq0_pc_o;
    inst_t             iq0_inst_o;
    logic              iq1_vld_o;
    pc_t               iq1_pc_o;
    inst_t             iq1_inst_o;
    logic              stall_iq_i;
    logic              flush_iq_i;

    // stimulus table with one row per test and the ops stored flat
    string  row_name[$];
    int     row_first[$];
    int     row_nops[$];
    int     row_occ[$];
    int     op_kind[$];
    pc_t    op_pc[$];
    int     op_cycles[$];
    logic   op_stall[$];

    // reference queue contents
    pc_t    mq_pc[$];
    inst_t  mq_inst[$];

    int     seed;
    int     test_errs;
    int     pass_cnt;
    int     fail_cnt;
    int     watchdog_ns = 0;

    always #5 clk = ~clk;

    inst_queue #(.DEPTH(DEPTH)) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_valid_i (icache_valid_i),
        .icache_pc_i    (icache_pc_i),
        .icache_data_i  (icache_data_i),
        .instq_full_o   (instq_full_o),
        .iq0_vld_o      (iq0_vld_o),
        .iq0_pc_o       (iq0_pc_o),
        .iq0_inst_o     (iq0_inst_o),
        .iq1_vld_o      (iq1_vld_o),
        .iq1_pc_o       (iq1_pc_o),
        .iq1_inst_o     (iq1_inst_o),
        .stall_iq_i     (stall_iq_i),
        .flush_iq_i     (flush_iq_i)
    );

    task automatic add_row(input string name, input int occ);
        row_name.push_back(name);
        row_first.push_back(op_kind.size());
        row_nops.push_back(0);
        row_occ.push_back(occ);
    endtask

    task automatic add_op(input int kind, input pc_t pc, input int cycles, input logic stall);
        int last;
        last = row_nops.size() - 1;
        op_kind.push_back(kind);
        op_pc.push_back(pc);
        op_cycles.push_back(cycles);
        op_stall.push_back(stall);
        row_nops[last] = row_nops[last] + 1;
    endtask

    task automatic build_table();
        add_row("slot0_line", 0);
        add_op(OP_PUSH, 64'h0000_0000_8000_1000, 1, 1'b0);
        add_op(OP_RUN, '0, 9, 1'b0);
        // slot 5 with the low byte bits set
        add_row("slot5_line", 0);
        add_op(OP_PUSH, 64'h0000_0000_8000_2016, 1, 1'b0);
        add_op(OP_RUN, '0, 7, 1'b0);
        // slot 13 leaves three entries
        add_row("odd_count", 0);
        add_op(OP_PUSH, 64'h0000_0000_8000_3034, 1, 1'b0);
        add_op(OP_RUN, '0, 3, 1'b0);
        add_row("fill_to_full", 32);
        add_op(OP_PUSH, 64'h0000_0000_8000_4000, 1, 1'b1);
        add_op(OP_PUSH, 64'h0000_0000_8000_4040, 1, 1'b1);
        add_op(OP_RUN, '0, 1, 1'b1);
        add_op(OP_PUSH, 64'h0000_0000_8000_4080, 1, 1'b1);
        add_op(OP_RUN, '0, 2, 1'b1);
        add_row("stall_hold", 0);
        add_op(OP_RUN, '0, 16, 1'b0);
        add_op(OP_PUSH, 64'h0000_0000_8000_5008, 1, 1'b0);
        add_op(OP_RUN, '0, 2, 1'b1);
        add_op(OP_PUSH, 64'h0000_0000_8000_5040, 1, 1'b1);
        add_op(OP_RUN, '0, 3, 1'b1);
        add_op(OP_RUN, '0, 16, 1'b0);
        add_row("flush", 0);
        add_op(OP_PUSH, 64'h0000_0000_8000_6000, 1, 1'b1);
        add_op(OP_PUSH, 64'h0000_0000_8000_6040, 1, 1'b1);
        add_op(OP_FLUSH, '0, 1, 1'b1);
        add_op(OP_RUN, '0, 1, 1'b0);
        add_op(OP_PUSH_FLUSH, 64'h0000_0000_8000_6080, 1, 1'b0);
        add_op(OP_RUN, '0, 1, 1'b0);
        add_op(OP_PUSH, 64'h0000_0000_8000_6004, 1, 1'b0);
        add_op(OP_RUN, '0, 9, 1'b0);
    endtask

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] words;
        for (int w = 0; w < LINE_INSTS; w++) begin
            words[w*INST_W +: INST_W] = $random(seed);
        end
        return words;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got=0x%h exp=0x%h", name, got, exp);
            test_errs = test_errs + 1;
        end
    endtask

    task automatic check_outputs();
        logic exp_v0;
        logic exp_v1;
        logic exp_full;
        exp_v0   = mq_pc.size() > 0;
        exp_v1   = mq_pc.size() > 1;
        exp_full = (DEPTH - mq_pc.size()) < LINE_INSTS;
        compare("iq0_vld_o", 64'(iq0_vld_o), 64'(exp_v0));
        compare("iq1_vld_o", 64'(iq1_vld_o), 64'(exp_v1));
        compare("instq_full_o", 64'(instq_full_o), 64'(exp_full));
        if (exp_v0) begin
            compare("iq0_pc_o", iq0_pc_o, mq_pc[0]);
            compare("iq0_inst_o", 64'(iq0_inst_o), 64'(mq_inst[0]));
        end
        if (exp_v1) begin
            compare("iq1_pc_o", iq1_pc_o, mq_pc[1]);
            compare("iq1_inst_o", 64'(iq1_inst_o), 64'(mq_inst[1]));
        end
        assert (!iq1_vld_o || iq0_vld_o) else begin
            $display("lane 1 is valid while lane 0 is not");
            test_errs = test_errs + 1;
        end
    endtask

    // what the queue should hold after the coming clock edge
    task automatic model_edge(input logic valid, input pc_t pc, input logic [LINE_W-1:0] data,
                              input logic stall, input logic flush);
        int   n_pop;
        int   slot;
        logic full;
        pc_t  base;
        full  = (DEPTH - mq_pc.size()) < LINE_INSTS;
        n_pop = stall ? 0 : (mq_pc.size() < 2 ? mq_pc.size() : 2);
        if (flush) begin
            mq_pc.delete();
            mq_inst.delete();
        end else begin
            for (int p = 0; p < n_pop; p++) begin
                void'(mq_pc.pop_front());
                void'(mq_inst.pop_front());
            end
            if (valid && !full) begin
                slot = int'(pc[5:2]);
                base = {pc[XLEN-1:6], 6'b0};
                for (int s = slot; s < LINE_INSTS; s++) begin
                    mq_pc.push_back(base + pc_t'(s * INST_BYTES));
                    mq_inst.push_back(data[s*INST_W +: INST_W]);
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic valid, input pc_t pc, input logic [LINE_W-1:0] data,
                               input logic stall, input logic flush);
        @(posedge clk);
        icache_valid_i <= valid;
        icache_pc_i    <= pc;
        icache_data_i  <= data;
        stall_iq_i     <= stall;
        flush_iq_i     <= flush;
        @(negedge clk);
        check_outputs();
        model_edge(valid, pc, data, stall, flush);
    endtask

    task automatic apply_op(input int idx);
        logic [LINE_W-1:0] data;
        data = '0;
        case (op_kind[idx])
            OP_PUSH: begin
                data = random_line();
                drive_cycle(1'b1, op_pc[idx], data, op_stall[idx], 1'b0);
            end
            OP_PUSH_FLUSH: begin
                data = random_line();
                drive_cycle(1'b1, op_pc[idx], data, op_stall[idx], 1'b1);
            end
            OP_FLUSH: drive_cycle(1'b0, '0, data, op_stall[idx], 1'b1);
            default: begin
                for (int c = 0; c < op_cycles[idx]; c++) begin
                    drive_cycle(1'b0, '0, data, op_stall[idx], 1'b0);
                end
            end
        endcase
    endtask

    initial begin
        int total;
        seed           = 32'hc9340640;
        pass_cnt       = 0;
        fail_cnt       = 0;
        rst_n          <= 1'b0;
        icache_valid_i <= 1'b0;
        icache_pc_i    <= '0;
        icache_data_i  <= '0;
        stall_iq_i     <= 1'b0;
        flush_iq_i     <= 1'b0;
        build_table();
        total = RESET_CYCLES + MARGIN_CYCLES + row_name.size();
        for (int i = 0; i < op_kind.size(); i++) begin
            total = total + (op_kind[i] == OP_RUN ? op_cycles[i] : 1);
        end
        watchdog_ns = total * 10;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < row_name.size(); r++) begin
            test_errs = 0;
            for (int o = row_first[r]; o < row_first[r] + row_nops[r]; o++) begin
                apply_op(o);
            end
            compare("occupancy", 64'(u_dut.u_ptr.occ), 64'(row_occ[r]));
            if (test_errs == 0) begin
                pass_cnt = pass_cnt + 1;
                $display("test %0d %s passed", r + 1, row_name[r]);
            end else begin
                fail_cnt = fail_cnt + 1;
                $display("test %0d %s failed with %0d errors", r + 1, row_name[r], test_errs);
            end
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // limit follows the table length
    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired, the run did not finish within %0d ns", watchdog_ns);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
